// ==== tb.f ====
src/xbar_addr_pkg.sv
src/xbar_queue_pkg.sv
src/bank_issue_if.sv
src/req_buffer.sv
src/bank_arbiter.sv
src/bank_port.sv
src/cache_xbar.sv
tb/tb_cache_xbar.sv

// ==== run.sh ====
#!/bin/sh
# build and run the crossbar testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
  --top-module tb_cache_xbar -f tb.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "Test failed" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
echo "simulation passed"

// ==== tb/tb_cache_xbar.sv ====
`timescale 1ns/1ns
module tb_cache_xbar;
  import xbar_addr_pkg::*;
  import xbar_queue_pkg::*;

  localparam int NUM_CH    = N_CH;
  localparam int BUF_DEPTH = DEPTH;
  localparam int RR_BANK   = 2;

  logic                    clk_i;
  logic                    rst_i;
  logic [NUM_CH-1:0]       ch_valid_i;
  logic [NUM_CH-1:0]       ch_ready_o;
  line_addr_t [NUM_CH-1:0] ch_addr_i;
  logic [N_BANK-1:0]       bank_valid_o;
  logic [N_BANK-1:0]       bank_ready_i;
  line_addr_t [N_BANK-1:0] bank_addr_o;
  ch_id_t [N_BANK-1:0]     bank_ch_o;

  logic [31:0] lfsr_q = 32'h5469f997;
  line_addr_t  sb_q [NUM_CH*N_BANK][$];  // expected addresses in channel major order

  cache_xbar #(
    .NUM_CH    (NUM_CH),
    .BUF_DEPTH (BUF_DEPTH)
  ) cache_xbar_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .ch_valid_i   (ch_valid_i),
    .ch_ready_o   (ch_ready_o),
    .ch_addr_i    (ch_addr_i),
    .bank_valid_o (bank_valid_o),
    .bank_ready_i (bank_ready_i),
    .bank_addr_o  (bank_addr_o),
    .bank_ch_o    (bank_ch_o)
  );

  always #5 clk_i = ~clk_i;

  // ------------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------------
  function automatic bank_idx_t bank_of(line_addr_t a);
    return a[4:3];  // byte address bits 8:7
  endfunction

  // first requester after the last grant in cyclic order
  function automatic ch_id_t next_rr(logic [NUM_CH-1:0] req, ch_id_t last);
    int c;
    c = int'(last);
    for (int k = 0; k < NUM_CH; k++) begin
      c = (c + 1) % NUM_CH;
      if (req[c]) return ch_id_t'(c);
    end
    return last;
  endfunction

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic line_addr_t addr_for_bank(bank_idx_t b);
    line_addr_t a;
    a      = line_addr_t'(rand_bits(LINE_AW));
    a[4:3] = b;
    return a;
  endfunction

  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_addr(string name, line_addr_t exp, line_addr_t act);
    if (exp !== act) begin
      $display("mismatch %s: expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_ch(string name, ch_id_t exp, ch_id_t act);
    if (exp !== act) begin
      $display("mismatch %s: expected %0d actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("mismatch %s: expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  // ------------------------------------------------------------------
  // scoreboard sampled on the rising edge
  // ------------------------------------------------------------------
  always @(posedge clk_i) begin : scoreboard
    int q;
    if (!rst_i) begin
      for (int b = 0; b < N_BANK; b++) begin
        if (bank_valid_o[b] && bank_ready_i[b]) begin
          if (int'(bank_ch_o[b]) >= NUM_CH) begin
            $display("bank %0d delivered from unknown channel %0d", b, bank_ch_o[b]);
            abort_run();
          end
          q = int'(bank_ch_o[b]) * N_BANK + b;
          if (sb_q[q].size() == 0) begin
            $display("bank %0d delivered an address channel %0d never sent", b, bank_ch_o[b]);
            abort_run();
          end
          check_addr("routing and order", sb_q[q].pop_front(), bank_addr_o[b]);
        end
      end
      for (int c = 0; c < NUM_CH; c++) begin
        if (ch_valid_i[c] && ch_ready_o[c])
          sb_q[c*N_BANK + int'(bank_of(ch_addr_i[c]))].push_back(ch_addr_i[c]);
      end
    end
  end

  task automatic wait_drain(string name);
    int n;
    int pending;
    n = 0;
    do begin
      @(negedge clk_i);
      pending = 0;
      for (int q = 0; q < NUM_CH*N_BANK; q++) pending += sb_q[q].size();
      n++;
      if (n > 1000) begin
        $display("%s: %0d requests never left the crossbar", name, pending);
        abort_run();
      end
    end while (pending != 0);
    check_bit({name, " bank outputs idle"}, 1'b0, |bank_valid_o);
  endtask

  // ------------------------------------------------------------------
  // tests
  // ------------------------------------------------------------------
  task automatic exercise_round_robin();
    int                left [NUM_CH];
    logic [NUM_CH-1:0] req;
    ch_id_t            last;
    ch_id_t            exp;
    int                seen;
    int                n;
    bank_ready_i          <= '1;
    bank_ready_i[RR_BANK] <= 1'b0;
    for (int i = 0; i < BUF_DEPTH; i++) begin
      @(posedge clk_i);
      ch_valid_i <= '1;  // all channels in lockstep
      for (int c = 0; c < NUM_CH; c++) ch_addr_i[c] <= addr_for_bank(bank_idx_t'(RR_BANK));
    end
    @(posedge clk_i);
    ch_valid_i <= '0;
    n = 0;
    while (!bank_valid_o[RR_BANK]) begin
      @(posedge clk_i);
      n++;
      if (n > 20) begin
        $display("bank %0d never presented a request", RR_BANK);
        abort_run();
      end
    end
    check_ch("round robin first holder", ch_id_t'(0), bank_ch_o[RR_BANK]);
    bank_ready_i[RR_BANK] <= 1'b1;
    for (int c = 0; c < NUM_CH; c++) left[c] = BUF_DEPTH;
    last = ch_id_t'(NUM_CH-1);
    seen = 0;
    n    = 0;
    while (seen < NUM_CH*BUF_DEPTH) begin
      @(posedge clk_i);
      n++;
      if (n > 4*NUM_CH*BUF_DEPTH) begin
        $display("round robin stalled after %0d transfers", seen);
        abort_run();
      end
      if (bank_valid_o[RR_BANK] && bank_ready_i[RR_BANK]) begin
        for (int c = 0; c < NUM_CH; c++) req[c] = left[c] > 0;
        exp = next_rr(req, last);
        check_ch("round robin order", exp, bank_ch_o[RR_BANK]);
        left[exp]--;
        last = exp;
        seen++;
      end
    end
    wait_drain("round robin");
  endtask

  task automatic stall_all_banks();
    int                acc;
    int                n;
    logic [N_BANK-1:0] held_v;
    line_addr_t        held_addr [N_BANK];
    ch_id_t            held_ch [N_BANK];
    @(posedge clk_i);
    bank_ready_i  <= '0;
    ch_valid_i[0] <= 1'b1;
    ch_addr_i[0]  <= line_addr_t'(rand_bits(LINE_AW));
    acc = 0;
    n   = 0;
    do begin
      @(posedge clk_i);
      if (ch_valid_i[0] && ch_ready_o[0]) acc++;
      ch_addr_i[0] <= line_addr_t'(rand_bits(LINE_AW));
      n++;
      if (n > 4*BUF_DEPTH) begin
        $display("ch_ready_o[0] never fell under back-pressure");
        abort_run();
      end
    end while (ch_ready_o[0]);
    ch_valid_i[0] <= 1'b0;
    check_bit("pushes accepted before ready fell", 1'b1, acc <= BUF_DEPTH + N_BANK);
    repeat (2) @(posedge clk_i);  // push to output latency
    held_v = bank_valid_o;
    for (int b = 0; b < N_BANK; b++) begin
      held_addr[b] = bank_addr_o[b];
      held_ch[b]   = bank_ch_o[b];
    end
    repeat (8) begin
      @(posedge clk_i);
      for (int b = 0; b < N_BANK; b++) begin
        if (held_v[b]) begin
          check_bit("held valid", 1'b1, bank_valid_o[b]);
          check_addr("held address", held_addr[b], bank_addr_o[b]);
          check_ch("held channel", held_ch[b], bank_ch_o[b]);
        end
      end
    end
    bank_ready_i <= '1;
    wait_drain("back-pressure");
  endtask

  task automatic drive_random_traffic(int cycles);
    logic [31:0]       r;
    logic [N_BANK-1:0] rdy;
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk_i);
      for (int c = 0; c < NUM_CH; c++) begin
        r = rand_bits(1);
        ch_valid_i[c] <= r[0];
        ch_addr_i[c]  <= line_addr_t'(rand_bits(LINE_AW));
      end
      r   = rand_bits(N_BANK);
      rdy = r[N_BANK-1:0];
      r   = rand_bits(N_BANK);
      bank_ready_i <= rdy | r[N_BANK-1:0];  // ready about 3 of 4 cycles
    end
    @(posedge clk_i);
    ch_valid_i   <= '0;
    bank_ready_i <= '1;
    wait_drain("random traffic");
  endtask

  initial begin
    clk_i        = 1'b0;
    rst_i        = 1'b1;
    ch_valid_i   = '0;
    ch_addr_i    = '0;
    bank_ready_i = '0;
    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);
    for (int b = 0; b < N_BANK; b++) check_bit("reset bank_valid_o", 1'b0, bank_valid_o[b]);
    for (int c = 0; c < NUM_CH; c++) check_bit("reset ch_ready_o", 1'b1, ch_ready_o[c]);
    exercise_round_robin();
    stall_all_banks();
    drive_random_traffic(2000);
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== src/cache_xbar.sv ====
`timescale 1ns/1ns
module cache_xbar #(
  parameter int NUM_CH    = xbar_queue_pkg::N_CH,
  parameter int BUF_DEPTH = xbar_queue_pkg::DEPTH
) (
  input  logic                                                 clk_i,
  input  logic                                                 rst_i,
  input  logic [NUM_CH-1:0]                                    ch_valid_i,
  output logic [NUM_CH-1:0]                                    ch_ready_o,
  input  xbar_addr_pkg::line_addr_t [NUM_CH-1:0]               ch_addr_i,
  output logic [xbar_addr_pkg::N_BANK-1:0]                     bank_valid_o,
  input  logic [xbar_addr_pkg::N_BANK-1:0]                     bank_ready_i,
  output xbar_addr_pkg::line_addr_t [xbar_addr_pkg::N_BANK-1:0] bank_addr_o,
  output xbar_queue_pkg::ch_id_t [xbar_addr_pkg::N_BANK-1:0]    bank_ch_o
);
  import xbar_addr_pkg::*;

  // buffer side, indexed by channel then bank
  logic [N_BANK-1:0]       buf_req   [NUM_CH];
  line_addr_t [N_BANK-1:0] buf_addr  [NUM_CH];
  logic [N_BANK-1:0]       buf_grant [NUM_CH];

  // arbiter side, indexed by bank then channel
  logic [NUM_CH-1:0]       arb_req   [N_BANK];
  line_addr_t [NUM_CH-1:0] arb_addr  [N_BANK];
  logic [NUM_CH-1:0]       arb_grant [N_BANK];

  // ------------------------------------------------------------------
  // channel request buffers
  // ------------------------------------------------------------------
  for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
    req_buffer #(
      .BUF_DEPTH (BUF_DEPTH)
    ) req_buffer_i (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .push_i       (ch_valid_i[c] & ch_ready_o[c]),
      .push_addr_i  (ch_addr_i[c]),
      .ready_o      (ch_ready_o[c]),
      .bank_req_o   (buf_req[c]),
      .bank_addr_o  (buf_addr[c]),
      .bank_grant_i (buf_grant[c])
    );
  end

  // channel x bank transpose
  for (genvar c = 0; c < NUM_CH; c++) begin : g_row
    for (genvar b = 0; b < N_BANK; b++) begin : g_col
      assign arb_req[b][c]   = buf_req[c][b];
      assign arb_addr[b][c]  = buf_addr[c][b];
      assign buf_grant[c][b] = arb_grant[b][c];
    end
  end

  // ------------------------------------------------------------------
  // per-bank arbiter and output register
  // ------------------------------------------------------------------
  for (genvar b = 0; b < N_BANK; b++) begin : g_bank
    bank_issue_if #(
      .NUM_CH (NUM_CH)
    ) issue_if (
      .clk_i (clk_i),
      .rst_i (rst_i)
    );

    bank_arbiter #(
      .NUM_CH (NUM_CH)
    ) bank_arbiter_i (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .req_i   (arb_req[b]),
      .addr_i  (arb_addr[b]),
      .grant_o (arb_grant[b]),
      .issue   (issue_if)
    );

    bank_port #(
      .NUM_CH (NUM_CH)
    ) bank_port_i (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .issue   (issue_if),
      .valid_o (bank_valid_o[b]),
      .ready_i (bank_ready_i[b]),
      .addr_o  (bank_addr_o[b]),
      .ch_o    (bank_ch_o[b])
    );
  end

endmodule

// ==== src/bank_port.sv ====
`timescale 1ns/1ns
module bank_port #(
  parameter int NUM_CH = xbar_queue_pkg::N_CH
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  bank_issue_if.port                issue,
  output logic                      valid_o,
  input  logic                      ready_i,
  output xbar_addr_pkg::line_addr_t addr_o,
  output xbar_queue_pkg::ch_id_t    ch_o
);

  // ------------------------------------------------------------------
  // one-entry output register
  // ------------------------------------------------------------------
  assign issue.ready = !valid_o || ready_i;  // empty or draining now

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else if (issue.ready) begin
      valid_o <= issue.valid;
    end
  end

  // payload only moves on a grant
  always_ff @(posedge clk_i) begin
    if (issue.valid) begin
      addr_o <= issue.addr;
      ch_o   <= issue.ch;
    end
  end

  // held request stays put until the bank takes it
  hold_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o && !ready_i |=> valid_o && $stable(addr_o) && $stable(ch_o));

  ch_range_a: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o |-> ch_o < NUM_CH);

endmodule

// ==== src/bank_arbiter.sv ====
`timescale 1ns/1ns
module bank_arbiter #(
  parameter int NUM_CH = xbar_queue_pkg::N_CH
) (
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  input  logic [NUM_CH-1:0]                      req_i,
  input  xbar_addr_pkg::line_addr_t [NUM_CH-1:0] addr_i,
  output logic [NUM_CH-1:0]                      grant_o,
  bank_issue_if.arb                              issue
);
  import xbar_queue_pkg::*;

  ch_id_t last_q;  // channel granted most recently
  ch_id_t win;
  logic   any_req;

  // ------------------------------------------------------------------
  // round robin pick
  // ------------------------------------------------------------------

  // offset NUM_CH is last_q itself, the lowest priority
  always_comb begin
    int c;
    win     = last_q;
    any_req = 1'b0;
    for (int k = NUM_CH; k >= 1; k--) begin
      c = (int'(last_q) + k) % NUM_CH;
      if (req_i[c]) begin
        win     = ch_id_t'(c);
        any_req = 1'b1;
      end
    end
  end

  always_comb begin
    grant_o = '0;
    if (any_req && issue.ready) grant_o[win] = 1'b1;
  end

  assign issue.valid = any_req && issue.ready;
  assign issue.addr  = addr_i[win];
  assign issue.ch    = win;

  // reset to the last channel so channel 0 goes first
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      last_q <= ch_id_t'(NUM_CH-1);
    end else if (issue.valid) begin
      last_q <= win;
    end
  end

  grant_onehot_a: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(grant_o));

endmodule

// ==== src/req_buffer.sv ====
`timescale 1ns/1ns
module req_buffer #(
  parameter int BUF_DEPTH = xbar_queue_pkg::DEPTH
) (
  input  logic                                                 clk_i,
  input  logic                                                 rst_i,
  input  logic                                                 push_i,
  input  xbar_addr_pkg::line_addr_t                            push_addr_i,
  output logic                                                 ready_o,
  output logic [xbar_addr_pkg::N_BANK-1:0]                     bank_req_o,
  output xbar_addr_pkg::line_addr_t [xbar_addr_pkg::N_BANK-1:0] bank_addr_o,
  input  logic [xbar_addr_pkg::N_BANK-1:0]                     bank_grant_i
);
  import xbar_addr_pkg::*;
  import xbar_queue_pkg::*;

  entry_idx_t           wr_ptr_q;
  entry_idx_t           rd_ptr_q;
  entry_cnt_t           used_q;
  line_addr_t           addr_mem [BUF_DEPTH];
  logic [BUF_DEPTH-1:0] pend_q   [N_BANK];  // one pending mask per bank
  logic [BUF_DEPTH-1:0] pend_nxt [N_BANK];
  entry_idx_t           sel_idx  [N_BANK];  // oldest pending slot per bank
  bank_idx_t            push_bank;
  logic                 head_pend;
  logic                 rd_adv;

  function automatic entry_idx_t wrap_inc(entry_idx_t ptr);
    return (ptr == entry_idx_t'(BUF_DEPTH-1)) ? '0 : ptr + entry_idx_t'(1);
  endfunction

  // ------------------------------------------------------------------
  // pointers and used count
  // ------------------------------------------------------------------
  assign push_bank = push_addr_i[BANK_LSB +: $bits(bank_idx_t)];
  assign ready_o   = used_q != entry_cnt_t'(BUF_DEPTH);  // registered state only

  always_comb begin
    head_pend = 1'b0;
    for (int b = 0; b < N_BANK; b++) begin
      head_pend |= pend_q[b][rd_ptr_q];
    end
  end

  // head slot already taken by its bank
  assign rd_adv = (used_q != '0) && !head_pend;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      used_q   <= '0;
    end else begin
      if (push_i) wr_ptr_q <= wrap_inc(wr_ptr_q);
      if (rd_adv) rd_ptr_q <= wrap_inc(rd_ptr_q);
      case ({push_i, rd_adv})
        2'b10:   used_q <= used_q + entry_cnt_t'(1);
        2'b01:   used_q <= used_q - entry_cnt_t'(1);
        default: ;  // both or neither
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) addr_mem[wr_ptr_q] <= push_addr_i;
  end

  // ------------------------------------------------------------------
  // per-bank pending masks
  // ------------------------------------------------------------------

  // scan downward from the youngest offset so the oldest match wins
  always_comb begin
    int idx;
    for (int b = 0; b < N_BANK; b++) begin
      sel_idx[b] = rd_ptr_q;
      for (int i = BUF_DEPTH-1; i >= 0; i--) begin
        idx = int'(rd_ptr_q) + i;
        if (idx >= BUF_DEPTH) idx -= BUF_DEPTH;
        if (pend_q[b][idx]) sel_idx[b] = entry_idx_t'(idx);
      end
    end
  end

  // a granted slot is never the free slot being written
  always_comb begin
    for (int b = 0; b < N_BANK; b++) begin
      pend_nxt[b] = pend_q[b];
      if (bank_grant_i[b]) pend_nxt[b][sel_idx[b]] = 1'b0;
      if (push_i && push_bank == bank_idx_t'(b)) pend_nxt[b][wr_ptr_q] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int b = 0; b < N_BANK; b++) pend_q[b] <= '0;
    end else begin
      for (int b = 0; b < N_BANK; b++) pend_q[b] <= pend_nxt[b];
    end
  end

  always_comb begin
    for (int b = 0; b < N_BANK; b++) begin
      bank_req_o[b]  = |pend_q[b];
      bank_addr_o[b] = addr_mem[sel_idx[b]];
    end
  end

  // top level must respect ready_o
  no_push_full_a: assert property (@(posedge clk_i) disable iff (rst_i)
    push_i |-> used_q < entry_cnt_t'(BUF_DEPTH));

  // arbiters only grant what this buffer offers
  grant_has_req_a: assert property (@(posedge clk_i) disable iff (rst_i)
    (bank_grant_i & ~bank_req_o) == '0);

endmodule

// ==== src/bank_issue_if.sv ====
`timescale 1ns/1ns
interface bank_issue_if #(
  parameter int NUM_CH = xbar_queue_pkg::N_CH
) (
  input logic clk_i,
  input logic rst_i
);
  import xbar_addr_pkg::*;
  import xbar_queue_pkg::*;

  logic       valid;  // grant in this cycle
  line_addr_t addr;
  ch_id_t     ch;
  logic       ready;  // port empty or draining

  modport arb  (output valid, output addr, output ch, input ready);
  modport port (input valid, input addr, input ch, output ready);

  // a grant only lands in a port that can take it, from a real channel
  issue_ok_a: assert property (@(posedge clk_i) disable iff (rst_i)
    valid |-> (ready && ch < NUM_CH));

endinterface

// ==== src/xbar_queue_pkg.sv ====
package xbar_queue_pkg;

  // ------------------------------------------------------------------
  // channel and buffer bookkeeping
  // ------------------------------------------------------------------

  localparam int N_CH  = 3;  // default channel count
  localparam int DEPTH = 6;  // default entries per buffer

  typedef logic [$clog2(N_CH)-1:0]    ch_id_t;
  typedef logic [$clog2(DEPTH)-1:0]   entry_idx_t;  // slot number
  typedef logic [$clog2(DEPTH+1)-1:0] entry_cnt_t;  // must reach DEPTH itself

endpackage

// ==== src/xbar_addr_pkg.sv ====
package xbar_addr_pkg;

  // ------------------------------------------------------------------
  // line address layout
  // ------------------------------------------------------------------

  // line address is byte address bits 31:4
  localparam int LINE_AW = 28;

  typedef logic [LINE_AW-1:0] line_addr_t;

  // bank field sits at line bits 4:3, byte bits 8:7
  localparam int BANK_LSB = 3;
  localparam int N_BANK   = 4;

  typedef logic [$clog2(N_BANK)-1:0] bank_idx_t;

endpackage
